//--- design/cache_pkg.sv
// cache_pkg: widths, address fields, tag entry layout and controller states for the 2-way cache
`default_nettype none

package cache_pkg;

	// cpu and memory both use a 16-bit byte address
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// address split is tag, set index, then byte offset from msb to lsb
	localparam int tag_w = 11;
	localparam int index_w = 3;
	localparam int offset_w = 2;

	// derived geometry, eight sets of four-byte lines
	localparam int num_sets = 1 << index_w;
	localparam int line_bytes = 1 << offset_w;
	localparam int line_w = line_bytes * data_w;

	typedef logic [addr_w-1:0] addr_t;

	// byte 0 of a line sits in the low bits
	typedef logic [line_w-1:0] line_t;

	// one tag ram word per way and set
	// used marks the way touched last, so the other way is the LRU one
	typedef struct packed {
		logic valid;
		logic used;
		logic dirty;
		logic [tag_w-1:0] tag;
	} tag_entry_t;

	// st_sweep clears every tag after reset
	// st_lookup is entered for new requests and again after an install
	typedef enum logic [2:0] {
		st_sweep,
		st_idle,
		st_lookup,
		st_evict,
		st_fill,
		st_install
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- design/burst_if.sv
// burst_if: start, address and line data between the cache controller and the memory burst engine
`default_nettype none
`timescale 1ns/1ps

interface burst_if;

	// single-cycle requests from the controller, never both in one cycle
	logic fill_start;
	logic evict_start;

	// line-aligned address, offset bits are zero
	cache_pkg::addr_t line_addr;

	// victim line, sampled by the engine together with evict_start
	cache_pkg::line_t evict_line;

	// refilled line, stable from done until the next fill begins
	cache_pkg::line_t fill_line;

	// single-cycle pulse at the end of the running transfer
	logic done;

	modport ctrl (
		output fill_start,
		output evict_start,
		output line_addr,
		output evict_line,
		input fill_line,
		input done
	);

	modport engine (
		input fill_start,
		input evict_start,
		input line_addr,
		input evict_line,
		output fill_line,
		output done
	);

endinterface

`default_nettype wire

//--- design/sync_ram.sv
// sync_ram: single-port RAM with registered read port, holds tag entries or cache lines
`default_nettype none
`timescale 1ns/1ps

module sync_ram #(
	parameter int depth_log2 = 3,
	parameter int width = 32
) (
	input logic clock,
	input logic [depth_log2-1:0] addr,
	input logic [width-1:0] din,
	input logic we,
	output logic [width-1:0] dout
);

	logic [width-1:0] mem [2**depth_log2];

	// write-first port, a word written at an edge is also the read data after that edge
	// this lets the lookup that follows an install see the new line at once
	always_ff @(posedge clock)
	begin
		if (we)
		begin
			mem[addr] <= din;
			dout <= din;
		end
		else
		begin
			dout <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- design/cache_lookup.sv
// cache_lookup: tag compare, byte select, write merge and LRU victim choice for the addressed set
`default_nettype none
`timescale 1ns/1ps

module cache_lookup (
	input cache_pkg::tag_entry_t tag_way0,
	input cache_pkg::tag_entry_t tag_way1,
	input cache_pkg::line_t line_way0,
	input cache_pkg::line_t line_way1,
	input logic [cache_pkg::tag_w-1:0] req_tag,
	input logic [cache_pkg::offset_w-1:0] req_offset,
	input logic [cache_pkg::data_w-1:0] wbyte,
	output logic hit_way0,
	output logic hit_way1,
	output logic [cache_pkg::data_w-1:0] rbyte,
	output cache_pkg::line_t merged_line,
	output logic victim_way,
	output logic victim_dirty
);

	cache_pkg::line_t hit_line;
	cache_pkg::tag_entry_t victim_entry;

	// a way hits only when its entry is valid and the stored tag matches
	assign hit_way0 = tag_way0.valid && (tag_way0.tag == req_tag);
	assign hit_way1 = tag_way1.valid && (tag_way1.tag == req_tag);

	// a line is installed only after both ways missed on its tag, so at most one way hits
	// on a miss the way 0 line flows through and is ignored by the controller
	assign hit_line = hit_way1 ? line_way1 : line_way0;

	// byte 0 of the line sits in the low bits
	assign rbyte = hit_line[req_offset*cache_pkg::data_w +: cache_pkg::data_w];

	// the hit line with the cpu byte dropped into the addressed slot
	always_comb
	begin
		merged_line = hit_line;
		merged_line[req_offset*cache_pkg::data_w +: cache_pkg::data_w] = wbyte;
	end

	// an empty way is filled first and way 0 goes before way 1
	// with both ways valid the one whose used bit is clear was touched longest ago
	always_comb
	begin
		if (!tag_way0.valid)
		begin
			victim_way = 1'b0;
		end
		else if (!tag_way1.valid)
		begin
			victim_way = 1'b1;
		end
		else if (!tag_way0.used)
		begin
			victim_way = 1'b0;
		end
		else
		begin
			victim_way = 1'b1;
		end
	end

	assign victim_entry = victim_way ? tag_way1 : tag_way0;

	// only a valid modified line has to go back to memory before the refill
	assign victim_dirty = victim_entry.valid && victim_entry.dirty;

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
// cache_ctrl: controller FSM for tag sweep, lookup, LRU and dirty updates, eviction and refill
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl (
	input logic clock,
	input logic reset_n,
	input logic cpu_read,
	input logic cpu_write,
	input cache_pkg::addr_t cpu_addr,
	input logic [cache_pkg::data_w-1:0] cpu_wdata,
	output logic stall,
	output logic [cache_pkg::data_w-1:0] cpu_rdata,
	output logic [cache_pkg::index_w-1:0] ram_index,
	output logic tag_we0,
	output logic tag_we1,
	output cache_pkg::tag_entry_t tag_wdata0,
	output cache_pkg::tag_entry_t tag_wdata1,
	output logic data_we0,
	output logic data_we1,
	output cache_pkg::line_t data_wdata,
	output logic [cache_pkg::tag_w-1:0] req_tag,
	output logic [cache_pkg::offset_w-1:0] req_offset,
	output logic [cache_pkg::data_w-1:0] req_wbyte,
	input cache_pkg::tag_entry_t tag_way0,
	input cache_pkg::tag_entry_t tag_way1,
	input cache_pkg::line_t line_way0,
	input cache_pkg::line_t line_way1,
	input logic hit_way0,
	input logic hit_way1,
	input logic [cache_pkg::data_w-1:0] rbyte,
	input cache_pkg::line_t merged_line,
	input logic victim_way,
	input logic victim_dirty,
	burst_if.ctrl bus
);

	cache_pkg::ctrl_state_t state;
	logic [cache_pkg::index_w-1:0] sweep_idx;
	logic [cache_pkg::index_w-1:0] req_index;
	cache_pkg::addr_t req_addr;
	logic [cache_pkg::data_w-1:0] req_wdata;
	logic req_write;
	logic victim_sel;
	logic hit;
	cache_pkg::tag_entry_t victim_entry;
	cache_pkg::tag_entry_t fill_entry;

	assign hit = hit_way0 || hit_way1;

	// the cpu is held off in every state but idle, so a hit costs exactly one stall cycle
	assign stall = (state != cache_pkg::st_idle);

	assign req_index = req_addr[cache_pkg::offset_w +: cache_pkg::index_w];
	assign req_tag = req_addr[cache_pkg::addr_w-1 -: cache_pkg::tag_w];
	assign req_offset = req_addr[cache_pkg::offset_w-1:0];
	assign req_wbyte = req_wdata;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= cache_pkg::st_sweep;
			sweep_idx <= '0;
			req_write <= 1'b0;
			victim_sel <= 1'b0;
		end
		else
		begin
			case (state)
				cache_pkg::st_sweep:
				begin
					sweep_idx <= sweep_idx + 1'b1;
					if (32'(sweep_idx) == cache_pkg::num_sets - 1)
					begin
						state <= cache_pkg::st_idle;
					end
				end
				cache_pkg::st_idle:
				begin
					// a read wins when the cpu raises both strobes
					req_write <= cpu_write && !cpu_read;
					if (cpu_read || cpu_write)
					begin
						state <= cache_pkg::st_lookup;
					end
				end
				cache_pkg::st_lookup:
				begin
					// the victim is remembered for the install that ends the miss
					victim_sel <= victim_way;
					if (hit)
					begin
						state <= cache_pkg::st_idle;
					end
					else if (victim_dirty)
					begin
						state <= cache_pkg::st_evict;
					end
					else
					begin
						state <= cache_pkg::st_fill;
					end
				end
				cache_pkg::st_evict:
				begin
					if (bus.done)
					begin
						state <= cache_pkg::st_fill;
					end
				end
				cache_pkg::st_fill:
				begin
					if (bus.done)
					begin
						state <= cache_pkg::st_install;
					end
				end
				cache_pkg::st_install:
				begin
					// replay the request, it now hits in the victim way
					state <= cache_pkg::st_lookup;
				end
				default:
				begin
					state <= cache_pkg::st_idle;
				end
			endcase
		end
	end

	// address and write byte are captured on every idle cycle and frozen once a request is taken
	always_ff @(posedge clock)
	begin
		if (state == cache_pkg::st_idle)
		begin
			req_addr <= cpu_addr;
			req_wdata <= cpu_wdata;
		end
	end

	// read data is held until the next read completes
	always_ff @(posedge clock)
	begin
		if (state == cache_pkg::st_lookup && hit && !req_write)
		begin
			cpu_rdata <= rbyte;
		end
	end

	// in idle the rams are addressed straight from the cpu so the set is ready in lookup
	always_comb
	begin
		case (state)
			cache_pkg::st_sweep: ram_index = sweep_idx;
			cache_pkg::st_idle: ram_index = cpu_addr[cache_pkg::offset_w +: cache_pkg::index_w];
			default: ram_index = req_index;
		endcase
	end

	// a freshly installed line is valid and clean, the replayed lookup sets its used bit
	always_comb
	begin
		fill_entry = '0;
		fill_entry.valid = 1'b1;
		fill_entry.tag = req_tag;
	end

	always_comb
	begin
		tag_we0 = 1'b0;
		tag_we1 = 1'b0;
		data_we0 = 1'b0;
		data_we1 = 1'b0;
		tag_wdata0 = tag_way0;
		tag_wdata1 = tag_way1;
		data_wdata = merged_line;
		case (state)
			cache_pkg::st_sweep:
			begin
				tag_we0 = 1'b1;
				tag_we1 = 1'b1;
				tag_wdata0 = '0;
				tag_wdata1 = '0;
			end
			cache_pkg::st_lookup:
			begin
				if (hit)
				begin
					// both entries are rewritten so exactly one used bit stays set
					tag_we0 = 1'b1;
					tag_we1 = 1'b1;
					tag_wdata0.used = hit_way0;
					tag_wdata1.used = hit_way1;
					if (req_write)
					begin
						data_we0 = hit_way0;
						data_we1 = hit_way1;
						tag_wdata0.dirty = tag_way0.dirty || hit_way0;
						tag_wdata1.dirty = tag_way1.dirty || hit_way1;
					end
				end
			end
			cache_pkg::st_install:
			begin
				data_wdata = bus.fill_line;
				if (victim_sel)
				begin
					tag_we1 = 1'b1;
					data_we1 = 1'b1;
					tag_wdata1 = fill_entry;
				end
				else
				begin
					tag_we0 = 1'b1;
					data_we0 = 1'b1;
					tag_wdata0 = fill_entry;
				end
			end
			default:
			begin
				tag_we0 = 1'b0;
			end
		endcase
	end

	// the set stays unchanged through evict and fill, so the lookup outputs hold still
	assign victim_entry = victim_way ? tag_way1 : tag_way0;

	assign bus.evict_start = (state == cache_pkg::st_lookup) && !hit && victim_dirty;

	// the refill starts right after the miss or on the cycle the write-back finishes
	assign bus.fill_start = ((state == cache_pkg::st_lookup) && !hit && !victim_dirty)
		|| ((state == cache_pkg::st_evict) && bus.done);

	// write-back goes to the victim's own address, a refill to the requested line
	assign bus.line_addr = ((state == cache_pkg::st_lookup) && victim_dirty)
		? {victim_entry.tag, req_index, {cache_pkg::offset_w{1'b0}}}
		: {req_addr[cache_pkg::addr_w-1:cache_pkg::offset_w], {cache_pkg::offset_w{1'b0}}};

	assign bus.evict_line = victim_way ? line_way1 : line_way0;

endmodule

`default_nettype wire

//--- design/mem_burst.sv
// mem_burst: moves whole lines to and from main memory as four byte transfers
`default_nettype none
`timescale 1ns/1ps

module mem_burst (
	input logic clock,
	input logic reset_n,
	burst_if.engine bus,
	input logic mem_ready,
	input logic mem_rvalid,
	input logic [cache_pkg::data_w-1:0] mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output cache_pkg::addr_t mem_addr,
	output logic [cache_pkg::data_w-1:0] mem_wdata
);

	// local to the engine, the controller never sees these states
	typedef enum logic [1:0] {
		bs_idle,
		bs_write,
		bs_read_req,
		bs_read_data
	} burst_state_t;

	burst_state_t state;
	logic [cache_pkg::offset_w-1:0] count;
	logic last_byte;
	logic done_q;
	cache_pkg::line_t shift;
	cache_pkg::addr_t base;

	assign last_byte = (32'(count) == cache_pkg::line_bytes - 1);

	// the byte counter doubles as the offset of the byte on the bus
	assign mem_addr = {base[cache_pkg::addr_w-1:cache_pkg::offset_w], count};
	assign mem_wdata = shift[cache_pkg::data_w-1:0];

	assign bus.fill_line = shift;
	assign bus.done = done_q;

	always_ff @(posedge clock or negedge reset_n)
	begin
		if (!reset_n)
		begin
			state <= bs_idle;
			count <= '0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			done_q <= 1'b0;
		end
		else
		begin
			done_q <= 1'b0;
			case (state)
				bs_idle:
				begin
					count <= '0;
					if (bus.evict_start)
					begin
						state <= bs_write;
					end
					else if (bus.fill_start)
					begin
						state <= bs_read_req;
					end
				end
				bs_write:
				begin
					// each strobe lasts one cycle and is only raised after ready was seen high
					if (mem_write)
					begin
						mem_write <= 1'b0;
						count <= count + 1'b1;
						if (last_byte)
						begin
							done_q <= 1'b1;
							state <= bs_idle;
						end
					end
					else if (mem_ready)
					begin
						mem_write <= 1'b1;
					end
				end
				bs_read_req:
				begin
					if (mem_read)
					begin
						mem_read <= 1'b0;
						state <= bs_read_data;
					end
					else if (mem_ready)
					begin
						mem_read <= 1'b1;
					end
				end
				bs_read_data:
				begin
					// memory paces the refill, each byte is marked by its own rvalid
					if (mem_rvalid)
					begin
						count <= count + 1'b1;
						if (last_byte)
						begin
							done_q <= 1'b1;
							state <= bs_idle;
						end
					end
				end
				default:
				begin
					state <= bs_idle;
				end
			endcase
		end
	end

	// line shift register, offset 0 leaves first and arrives first
	always_ff @(posedge clock)
	begin
		case (state)
			bs_idle:
			begin
				base <= bus.line_addr;
				if (bus.evict_start)
				begin
					shift <= bus.evict_line;
				end
			end
			bs_write:
			begin
				if (mem_write)
				begin
					shift <= shift >> cache_pkg::data_w;
				end
			end
			bs_read_data:
			begin
				// after four bytes the first one has reached the low end
				if (mem_rvalid)
				begin
					shift <= {mem_rdata, shift[cache_pkg::line_w-1:cache_pkg::data_w]};
				end
			end
			default:
			begin
				shift <= shift;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- design/cache_2way.sv
// cache_2way: top of the 2-way write-back cache, tag and data rams, lookup, controller, burst engine
`default_nettype none
`timescale 1ns/1ps

module cache_2way (
	input logic clock,
	input logic reset_n,
	input logic cpu_read,
	input logic cpu_write,
	input cache_pkg::addr_t cpu_addr,
	input logic [cache_pkg::data_w-1:0] cpu_wdata,
	output logic stall,
	output logic [cache_pkg::data_w-1:0] cpu_rdata,
	input logic mem_ready,
	input logic mem_rvalid,
	input logic [cache_pkg::data_w-1:0] mem_rdata,
	output logic mem_read,
	output logic mem_write,
	output cache_pkg::addr_t mem_addr,
	output logic [cache_pkg::data_w-1:0] mem_wdata
);

	logic [cache_pkg::index_w-1:0] ram_index;
	logic tag_we0;
	logic tag_we1;
	logic data_we0;
	logic data_we1;
	cache_pkg::tag_entry_t tag_wdata0;
	cache_pkg::tag_entry_t tag_wdata1;
	cache_pkg::tag_entry_t tag_rd0;
	cache_pkg::tag_entry_t tag_rd1;
	cache_pkg::line_t data_wdata;
	cache_pkg::line_t line_rd0;
	cache_pkg::line_t line_rd1;
	logic [cache_pkg::tag_w-1:0] req_tag;
	logic [cache_pkg::offset_w-1:0] req_offset;
	logic [cache_pkg::data_w-1:0] req_wbyte;
	logic hit_way0;
	logic hit_way1;
	logic [cache_pkg::data_w-1:0] rbyte;
	cache_pkg::line_t merged_line;
	logic victim_way;
	logic victim_dirty;

	burst_if bus ();

	// all four rams share one index, each way has its own write enable
	sync_ram #(
		.depth_log2(cache_pkg::index_w),
		.width($bits(cache_pkg::tag_entry_t))
	) tag_ram0 (
		.clock(clock),
		.addr(ram_index),
		.din(tag_wdata0),
		.we(tag_we0),
		.dout(tag_rd0)
	);

	sync_ram #(
		.depth_log2(cache_pkg::index_w),
		.width($bits(cache_pkg::tag_entry_t))
	) tag_ram1 (
		.clock(clock),
		.addr(ram_index),
		.din(tag_wdata1),
		.we(tag_we1),
		.dout(tag_rd1)
	);

	// one write bus serves both data arrays
	sync_ram #(
		.depth_log2(cache_pkg::index_w),
		.width(cache_pkg::line_w)
	) data_ram0 (
		.clock(clock),
		.addr(ram_index),
		.din(data_wdata),
		.we(data_we0),
		.dout(line_rd0)
	);

	sync_ram #(
		.depth_log2(cache_pkg::index_w),
		.width(cache_pkg::line_w)
	) data_ram1 (
		.clock(clock),
		.addr(ram_index),
		.din(data_wdata),
		.we(data_we1),
		.dout(line_rd1)
	);

	cache_lookup u_lookup (
		.tag_way0(tag_rd0),
		.tag_way1(tag_rd1),
		.line_way0(line_rd0),
		.line_way1(line_rd1),
		.req_tag(req_tag),
		.req_offset(req_offset),
		.wbyte(req_wbyte),
		.hit_way0(hit_way0),
		.hit_way1(hit_way1),
		.rbyte(rbyte),
		.merged_line(merged_line),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty)
	);

	cache_ctrl u_ctrl (
		.clock(clock),
		.reset_n(reset_n),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.stall(stall),
		.cpu_rdata(cpu_rdata),
		.ram_index(ram_index),
		.tag_we0(tag_we0),
		.tag_we1(tag_we1),
		.tag_wdata0(tag_wdata0),
		.tag_wdata1(tag_wdata1),
		.data_we0(data_we0),
		.data_we1(data_we1),
		.data_wdata(data_wdata),
		.req_tag(req_tag),
		.req_offset(req_offset),
		.req_wbyte(req_wbyte),
		.tag_way0(tag_rd0),
		.tag_way1(tag_rd1),
		.line_way0(line_rd0),
		.line_way1(line_rd1),
		.hit_way0(hit_way0),
		.hit_way1(hit_way1),
		.rbyte(rbyte),
		.merged_line(merged_line),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.bus(bus.ctrl)
	);

	mem_burst u_burst (
		.clock(clock),
		.reset_n(reset_n),
		.bus(bus.engine),
		.mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

endmodule

`default_nettype wire

//--- verif/cache_props.sv
// cache_props: memory strobe protocol assertions bound into the cache top level
`default_nettype none
`timescale 1ns/1ps

module cache_props (
	input logic clock,
	input logic reset_n,
	input logic mem_read,
	input logic mem_write,
	input logic mem_ready,
	input logic stall
);

	// the engine runs one transfer at a time, so read and write never overlap
	no_overlap: assert property (@(posedge clock) !(mem_read && mem_write))
		else $error("mem_read and mem_write are high in the same cycle");

	// nothing reaches memory while the cache is held in reset
	quiet_in_reset: assert property (@(posedge clock) !reset_n |-> !mem_read && !mem_write)
		else $error("memory strobe raised during reset");

	// the cpu is held off while the tags are still being cleared
	stall_in_reset: assert property (@(posedge clock) !reset_n |-> stall)
		else $error("stall is low during reset");

	// a strobe is only raised on an edge where ready was sampled high
	write_after_ready: assert property (@(posedge clock) disable iff (!reset_n)
		mem_write |-> $past(mem_ready))
		else $error("mem_write raised without mem_ready on the edge before");

	read_after_ready: assert property (@(posedge clock) disable iff (!reset_n)
		mem_read |-> $past(mem_ready))
		else $error("mem_read raised without mem_ready on the edge before");

	// each strobe carries one byte or one request and lasts a single cycle
	write_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
		mem_write |=> !mem_write)
		else $error("mem_write held high for more than one cycle");

	read_single_cycle: assert property (@(posedge clock) disable iff (!reset_n)
		mem_read |=> !mem_read)
		else $error("mem_read held high for more than one cycle");

endmodule

bind cache_2way cache_props props (
	.clock(clock),
	.reset_n(reset_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_ready(mem_ready),
	.stall(stall)
);

`default_nettype wire

//--- verif/cache_tb.sv
// cache_tb: testbench for the 2-way write-back cache with memory model, shadow model and watchdog
`default_nettype none
`timescale 1ns/1ps

module cache_tb;

	localparam int clock_period = 20;
	localparam int directed_ops = 14;
	localparam int random_ops = 400;
	localparam int total_ops = directed_ops + random_ops;

	logic clock = 1'b0;
	logic reset_n;
	logic cpu_read;
	logic cpu_write;
	cache_pkg::addr_t cpu_addr;
	logic [cache_pkg::data_w-1:0] cpu_wdata;
	logic stall;
	logic [cache_pkg::data_w-1:0] cpu_rdata;
	logic mem_ready;
	logic mem_rvalid;
	logic [cache_pkg::data_w-1:0] mem_rdata;
	logic mem_read;
	logic mem_write;
	cache_pkg::addr_t mem_addr;
	logic [cache_pkg::data_w-1:0] mem_wdata;

	// main memory contents and the byte view the cpu expects to see
	logic [cache_pkg::data_w-1:0] memory [65536];
	logic [cache_pkg::data_w-1:0] shadow [65536];

	// refill in progress inside the memory model
	cache_pkg::addr_t fill_base;
	int fill_left = 0;
	int read_strobes = 0;
	int write_strobes = 0;
	int reads_before;
	int writes_before;
	int stall_cycles;
	int checks = 0;
	int errors = 0;

	cache_2way dut (
		.clock(clock),
		.reset_n(reset_n),
		.cpu_read(cpu_read),
		.cpu_write(cpu_write),
		.cpu_addr(cpu_addr),
		.cpu_wdata(cpu_wdata),
		.stall(stall),
		.cpu_rdata(cpu_rdata),
		.mem_ready(mem_ready),
		.mem_rvalid(mem_rvalid),
		.mem_rdata(mem_rdata),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata)
	);

	always #(clock_period / 2) clock = ~clock;

	function automatic cache_pkg::addr_t make_addr(input logic [cache_pkg::tag_w-1:0] tag,
		input logic [cache_pkg::index_w-1:0] index, input logic [cache_pkg::offset_w-1:0] offset);
		return {tag, index, offset};
	endfunction

	task automatic compare_byte(input string name, input logic [7:0] got, input logic [7:0] want);
		checks++;
		assert (got == want)
		else
		begin
			errors++;
			$display("Mismatch at time %0t: %s got %02h expected %02h", $time, name, got, want);
		end
	endtask

	task automatic expect_count(input string name, input int got, input int want);
		checks++;
		assert (got == want)
		else
		begin
			errors++;
			$display("Mismatch at time %0t: %s got %0d expected %0d", $time, name, got, want);
		end
	endtask

	// one cpu request, started on a falling edge while stall is low, held until stall falls
	task automatic cpu_access(input logic is_write, input cache_pkg::addr_t addr,
		input logic [7:0] wdata);
		cpu_read = !is_write;
		cpu_write = is_write;
		cpu_addr = addr;
		cpu_wdata = wdata;
		reads_before = read_strobes;
		writes_before = write_strobes;
		stall_cycles = 0;
		@(negedge clock);
		while (stall)
		begin
			stall_cycles++;
			@(negedge clock);
		end
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		checks++;
		assert (stall_cycles > 0)
		else
		begin
			errors++;
			$display("request to address %04h was never accepted by the cache", addr);
		end
		if (is_write)
		begin
			shadow[addr] = wdata;
		end
		else
		begin
			compare_byte("cpu_rdata", cpu_rdata, shadow[addr]);
		end
	endtask

	// memory model, pulls ready low at random and paces refill bytes with random gaps
	initial
	begin
		int i;
		void'($urandom(32'h7987));
		for (i = 0; i < 65536; i++)
		begin
			memory[16'(i)] = 8'($urandom ^ i ^ (i >> 8));
			shadow[16'(i)] = memory[16'(i)];
		end
		mem_ready = 1'b0;
		mem_rvalid = 1'b0;
		mem_rdata = '0;
		forever
		begin
			@(negedge clock);
			mem_rvalid = 1'b0;
			// bytes come back no earlier than the edge after the read strobe
			if (fill_left > 0 && $urandom_range(2) != 0)
			begin
				mem_rvalid = 1'b1;
				mem_rdata = memory[fill_base + 16'(4 - fill_left)];
				fill_left--;
			end
			if (mem_read)
			begin
				read_strobes++;
				fill_base = mem_addr;
				fill_left = 4;
			end
			if (mem_write)
			begin
				write_strobes++;
				memory[mem_addr] = mem_wdata;
			end
			mem_ready = ($urandom_range(3) != 0);
		end
	end

	initial
	begin
		cache_pkg::addr_t a;
		cache_pkg::addr_t line_a;
		int n;
		int k;
		cpu_read = 1'b0;
		cpu_write = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		reset_n = 1'b0;
		repeat (3) @(negedge clock);
		reset_n = 1'b1;
		// stall stays high while the tags are swept
		while (stall)
		begin
			@(negedge clock);
		end

		// read miss on an empty set loads the line with a single refill
		a = make_addr(11'h123, 3'd1, 2'd0);
		cpu_access(1'b0, a, 8'h00);
		compare_byte("cpu_rdata", cpu_rdata, memory[a]);
		expect_count("mem_read strobes", read_strobes - reads_before, 1);
		expect_count("mem_write strobes", write_strobes - writes_before, 0);

		// another byte of the same line is a hit with one stall cycle
		cpu_access(1'b0, a + 16'd1, 8'h00);
		expect_count("stall cycles", stall_cycles, 1);
		expect_count("mem_read strobes", read_strobes - reads_before, 0);
		expect_count("mem_write strobes", write_strobes - writes_before, 0);

		// a write hit stays in the cache and reads back at once
		cpu_access(1'b1, a + 16'd2, 8'h5a);
		expect_count("stall cycles", stall_cycles, 1);
		expect_count("mem_write strobes", write_strobes - writes_before, 0);
		cpu_access(1'b0, a + 16'd2, 8'h00);
		expect_count("mem_write strobes", write_strobes - writes_before, 0);

		// write miss allocates the line, the rest of it still comes from memory
		a = make_addr(11'h155, 3'd2, 2'd3);
		cpu_access(1'b1, a, 8'hc3);
		expect_count("mem_read strobes", read_strobes - reads_before, 1);
		cpu_access(1'b0, a, 8'h00);
		expect_count("stall cycles", stall_cycles, 1);
		for (k = 0; k < 3; k++)
		begin
			cpu_access(1'b0, a - 16'(k + 1), 8'h00);
			compare_byte("cpu_rdata", cpu_rdata, memory[a - 16'(k + 1)]);
		end

		// LRU in set 5, A is dirty in way 0 and B is clean in way 1
		line_a = make_addr(11'h0a1, 3'd5, 2'd0);
		cpu_access(1'b1, line_a + 16'd1, 8'h3c);
		cpu_access(1'b0, make_addr(11'h0b2, 3'd5, 2'd2), 8'h00);
		cpu_access(1'b0, line_a + 16'd1, 8'h00);
		expect_count("stall cycles", stall_cycles, 1);
		// C replaces B, the least recently used, which needs no write-back
		cpu_access(1'b0, make_addr(11'h0c3, 3'd5, 2'd1), 8'h00);
		expect_count("mem_read strobes", read_strobes - reads_before, 1);
		expect_count("mem_write strobes", write_strobes - writes_before, 0);
		// D replaces A, whose modified line goes back to memory first
		cpu_access(1'b0, make_addr(11'h0d4, 3'd5, 2'd3), 8'h00);
		expect_count("mem_read strobes", read_strobes - reads_before, 1);
		expect_count("mem_write strobes", write_strobes - writes_before, 4);
		for (k = 0; k < 4; k++)
		begin
			compare_byte("memory", memory[line_a + 16'(k)], shadow[line_a + 16'(k)]);
		end

		// random mix over sets 0 to 3 and six tags, so lines are evicted often
		for (n = 0; n < random_ops; n++)
		begin
			a = make_addr(11'(($urandom_range(5) * 19) + 32'h2a0), 3'($urandom_range(3)),
				2'($urandom_range(3)));
			cpu_access(1'($urandom_range(1)), a, 8'($urandom));
		end

		$display("checks run %0d, errors %0d", checks, errors);
		if (errors == 0)
		begin
			$display("TESTBENCH PASSED");
		end
		else
		begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

	// each operation gets a budget of 200 clock cycles
	initial
	begin
		#(total_ops * 200 * clock_period);
		$display("timeout, the cache did not complete %0d operations in time", total_ops);
		$display("checks run %0d, errors %0d", checks, errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
design/cache_pkg.sv
design/burst_if.sv
design/sync_ram.sv
design/cache_lookup.sv
design/cache_ctrl.sv
design/mem_burst.sv
design/cache_2way.sv
verif/cache_props.sv
verif/cache_tb.sv

//--- Makefile
TOP := cache_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): verilog.f $(shell cat verilog.f)
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f -Mdir obj_dir

# the log decides the result, a missing closing message counts as failure too
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" sim.log; then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf obj_dir sim.log
